/* pipe_trace_stim.txt */
# T name | P fetch_valid instr stall flush | E instr seq stalls fetch exec wb (offsets)
# D drain | R read records | S status | X error offset | W pop data
T reset_errors
S 100
X 04
X 14
X 1c
W 0
S 100
T clean_flow
P 1 a0000000 0 0
P 1 a0000001 0 0
P 1 a0000002 0 0
P 1 a0000003 0 0
D
E a0000000 0 0 0 2 4
E a0000001 1 0 1 3 5
E a0000002 2 0 2 4 6
E a0000003 3 0 3 5 7
R
S 100
T stall_hold
P 1 b0000000 0 0
P 1 b0000001 0 0
P 1 bad00000 1 0
P 1 bad00001 1 0
P 0 0 0 0
D
E b0000000 4 2 0 4 6
E b0000001 5 2 1 5 7
R
S 100
T flush_squash
P 1 c0000000 0 0
P 1 c0000001 0 0
P 1 c0000002 0 0
P 1 c0000003 0 0
P 1 bad00002 0 1
P 1 c0000004 0 0
D
E c0000000 6 0 0 2 4
E c0000001 7 0 1 3 5
E c0000004 a 0 5 7 9
R
S 100
T overflow
P 1 d0000000 0 0
P 1 d0000001 0 0
P 1 d0000002 0 0
P 1 d0000003 0 0
P 1 d0000004 0 0
P 1 d0000005 0 0
P 1 d0000006 0 0
P 1 d0000007 0 0
P 1 d0000008 0 0
P 1 d0000009 0 0
D
S 208
E d0000000 b 0 0 2 4
E d0000001 c 0 1 3 5
E d0000002 d 0 2 4 6
E d0000003 e 0 3 5 7
E d0000004 f 0 4 6 8
E d0000005 10 0 5 7 9
E d0000006 11 0 6 8 a
E d0000007 12 0 7 9 b
R
S 300
W 1
S 100

/* pipe_trace.f */
pipe_trace_pkg.sv
trace_tracker.sv
trace_fifo.sv
trace_apb_regs.sv
pipe_trace_top.sv
tb_clock_gen.sv
pipe_trace_props.sv
pipe_trace_tb.sv

/* Makefile */
# Verilator build for the pipeline trace unit

TOP := pipe_trace_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -f pipe_trace.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* pipe_trace_tb.sv */
/*
 * testbench for the pipeline trace unit
 * stim file driven pipeline, APB readback and record checks
 */
`default_nettype none

module pipe_trace_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import pipe_trace_pkg::*;

    logic        clk;
    logic        rst;
    logic        fetch_valid;
    logic [31:0] fetch_instr;
    logic        stall;
    logic        flush;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;

    // mirror of the cycle stamp counter
    cycle_t      tb_cyc;
    cycle_t      base;
    logic [31:0] lfsr;
    string       lines[$];
    trace_rec_t  exp_q[$];
    string       test_name;
    int          test_errs;
    int          n_pass;
    int          n_fail;
    int          n_lines;

    tb_clock_gen clk_gen_i (.clk(clk), .rst(rst));

    pipe_trace_top #(.DEPTH(8)) dut_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .stall       (stall),
        .flush       (flush),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp)
    );

    bind trace_apb_regs pipe_trace_props #(.DEPTH(DEPTH)) props_i (
        .clk(clk), .rst(rst), .req(req), .pop(pop), .empty(empty), .count(count)
    );

    // counts from 0 in the first cycle after reset
    always @(posedge clk) begin
        if (rst) begin
            tb_cyc <= '0;
        end else begin
            tb_cyc <= tb_cyc + 16'd1;
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        repeat (n) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_no_err(input string what, input logic err);
        if (err) begin
            $display("unexpected slave error on the %s access in test %s", what, test_name);
            test_errs++;
        end
    endtask

    // setup and access cycles with the read sampled mid access
    task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #2;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic end_test();
        if (test_name != "") begin
            if (test_errs == 0) begin
                $display("test %s: passed", test_name);
                n_pass++;
            end else begin
                $display("test %s: failed with %0d errors", test_name, test_errs);
                n_fail++;
            end
        end
    endtask

    // pop every queued record with random idle gaps between reads
    task automatic read_records();
        trace_rec_t  e;
        logic [31:0] d;
        logic        err;
        int          gap;
        while (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            take_bits(2, gap);
            repeat (gap) @(negedge clk);
            apb_xfer(1'b0, REG_INSTR, 32'd0, d, err);
            compare("instr", e.instr, d);
            check_no_err("instr", err);
            apb_xfer(1'b0, REG_INFO, 32'd0, d, err);
            compare("info", {e.seq, e.stalls, e.fetch_cycle}, d);
            check_no_err("info", err);
            apb_xfer(1'b0, REG_CYCLES, 32'd0, d, err);
            compare("cycles", {e.exec_cycle, e.wb_cycle}, d);
            check_no_err("cycles", err);
            apb_xfer(1'b1, REG_POP, 32'd0, d, err);
            check_no_err("pop", err);
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] f;
        logic        err;
        trace_rec_t  r;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        apb_req     = '0;
        lfsr        = 32'hcf93d76c;
        test_name   = "";
        test_errs   = 0;
        n_pass      = 0;
        n_fail      = 0;
        fd = $fopen("pipe_trace_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            $display("Test failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
            n_lines = lines.size();
            wait (!rst);
            @(negedge clk);
            foreach (lines[i]) begin
                line = lines[i];
                case (line[0])
                    "T": begin
                        end_test();
                        n = $sscanf(line, "T %s", test_name);
                        test_errs = 0;
                        base = tb_cyc;
                    end
                    "P": begin
                        n = $sscanf(line, "P %h %h %h %h", a, b, c, d);
                        fetch_valid = a[0];
                        fetch_instr = b;
                        stall       = c[0];
                        flush       = d[0];
                        @(negedge clk);
                        fetch_valid = 1'b0;
                        stall       = 1'b0;
                        flush       = 1'b0;
                    end
                    // pipeline depth plus the FIFO write
                    "D": repeat (8) @(negedge clk);
                    "E": begin
                        n = $sscanf(line, "E %h %h %h %h %h %h", a, b, c, d, e, f);
                        r.instr       = a;
                        r.seq         = b[7:0];
                        r.stalls      = c[7:0];
                        r.fetch_cycle = base + d[15:0];
                        r.exec_cycle  = base + e[15:0];
                        r.wb_cycle    = base + f[15:0];
                        exp_q.push_back(r);
                    end
                    "R": read_records();
                    "S": begin
                        n = $sscanf(line, "S %h", a);
                        apb_xfer(1'b0, REG_STATUS, 32'd0, d, err);
                        compare("status", a, d);
                        check_no_err("status", err);
                    end
                    "X": begin
                        n = $sscanf(line, "X %h", a);
                        apb_xfer(1'b0, a[4:0], 32'd0, d, err);
                        if (!err) begin
                            $display("no slave error on offset %h in test %s", a[4:0], test_name);
                            test_errs++;
                        end
                    end
                    "W": begin
                        n = $sscanf(line, "W %h", a);
                        apb_xfer(1'b1, REG_POP, a, d, err);
                        check_no_err("pop", err);
                    end
                    default: ;
                endcase
            end
            end_test();
            $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
            if (n_fail == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

    // 40 cycles per stim line
    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 40) @(posedge clk);
        $display("watchdog timeout, the run did not finish");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* pipe_trace_props.sv */
/*
 * concurrent checks on the APB phases, the pop pulse and the FIFO flags
 */
`default_nettype none

module pipe_trace_props #(
    parameter int unsigned DEPTH = 8
) (
    input logic                     clk,
    input logic                     rst,
    input pipe_trace_pkg::apb_req_t req,
    input logic                     pop,
    input logic                     empty,
    input logic [$clog2(DEPTH):0]   count
);
    timeunit 1ns;
    timeprecision 1ps;
    import pipe_trace_pkg::*;

    localparam int unsigned CW = $clog2(DEPTH) + 1;

    // access cycle must come straight after a setup cycle
    apb_setup_first: assert property (@(posedge clk) disable iff (rst)
        (req.psel && req.penable) |-> $past(req.psel && !req.penable))
        else $error("APB access cycle without a setup cycle");

    // a pop pulse takes one record off a non-empty FIFO unless a push lands with it
    pop_one_record: assert property (@(posedge clk) disable iff (rst)
        (pop && !empty) |=> (count == $past(count) - 1'b1) || (count == $past(count)))
        else $error("pop did not take exactly one record");

    // occupancy stays within the depth and reads zero exactly when empty
    count_in_range: assert property (@(posedge clk) disable iff (rst)
        (count <= CW'(DEPTH)) && (empty == (count == '0)))
        else $error("FIFO count out of range or disagrees with the empty flag");

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
/*
 * testbench clock and reset generator
 */
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* pipe_trace_top.sv */
/*
 * pipeline trace unit top level
 * tracker, record FIFO and APB register block
 */
`default_nettype none

module pipe_trace_top #(
    parameter int unsigned DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetch_valid,
    input  logic [31:0]              fetch_instr,
    input  logic                     stall,
    input  logic                     flush,
    input  pipe_trace_pkg::apb_req_t apb_req,
    output pipe_trace_pkg::apb_rsp_t apb_rsp
);
    import pipe_trace_pkg::*;

    // tracker to FIFO
    logic                   rec_valid;
    trace_rec_t             rec;

    // FIFO to register block
    trace_rec_t             head;
    logic                   empty;
    logic [$clog2(DEPTH):0] count;
    logic                   overflow;

    // register block to FIFO
    logic                   pop;
    logic                   clr_ovf;

    ////////////////////
    // producer
    ////////////////////

    trace_tracker tracker_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .stall       (stall),
        .flush       (flush),
        .rec_valid   (rec_valid),
        .rec         (rec)
    );

    // buffer
    trace_fifo #(
        .DEPTH (DEPTH)
    ) fifo_i (
        .clk      (clk),
        .rst      (rst),
        .push     (rec_valid),
        .push_rec (rec),
        .pop      (pop),
        .clr_ovf  (clr_ovf),
        .head     (head),
        .empty    (empty),
        .count    (count),
        .overflow (overflow)
    );

    // consumer
    trace_apb_regs #(
        .DEPTH (DEPTH)
    ) regs_i (
        .clk      (clk),
        .rst      (rst),
        .req      (apb_req),
        .head     (head),
        .empty    (empty),
        .count    (count),
        .overflow (overflow),
        .rsp      (apb_rsp),
        .pop      (pop),
        .clr_ovf  (clr_ovf)
    );

endmodule

`default_nettype wire

/* trace_apb_regs.sv */
/*
 * APB register block for the trace FIFO
 * status and head record reads, pop and overflow clear on write
 */
`default_nettype none

module trace_apb_regs #(
    parameter int unsigned DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  pipe_trace_pkg::apb_req_t   req,
    input  pipe_trace_pkg::trace_rec_t head,
    input  logic                       empty,
    input  logic [$clog2(DEPTH):0]     count,
    input  logic                       overflow,
    output pipe_trace_pkg::apb_rsp_t   rsp,
    output logic                       pop,
    output logic                       clr_ovf
);
    import pipe_trace_pkg::*;

    localparam int unsigned CW = $clog2(DEPTH) + 1;

    // previous cycle was an APB setup cycle
    logic        setup_q;
    logic        access;
    logic        mapped;
    // register reads from the head record
    logic        needs_rec;
    logic [31:0] rd_data;
    logic [7:0]  count_field;

    ////////////////////
    // phase tracking
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= req.psel && !req.penable;
        end
    end

    // access cycle only right after setup
    assign access = req.psel && req.penable && setup_q;

    // count zero-extended into the status byte
    assign count_field = {{(8 - CW){1'b0}}, count};

    ////////////////////
    // address decode
    ////////////////////

    always_comb begin
        mapped    = 1'b1;
        needs_rec = 1'b0;
        rd_data   = '0;
        case (req.paddr)
            REG_STATUS: begin
                rd_data = {22'd0, overflow, empty, count_field};
            end
            REG_INSTR: begin
                needs_rec = 1'b1;
                rd_data   = head.instr;
            end
            REG_INFO: begin
                needs_rec = 1'b1;
                rd_data   = {head.seq, head.stalls, head.fetch_cycle};
            end
            REG_CYCLES: begin
                needs_rec = 1'b1;
                rd_data   = {head.exec_cycle, head.wb_cycle};
            end
            // write-only, reads back zero
            REG_POP: begin
                rd_data = '0;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    assign rsp.prdata  = rd_data;
    // unmapped offset, or a record read with nothing queued
    assign rsp.pslverr = access && (!mapped || (!req.pwrite && needs_rec && empty));

    // one pulse per access cycle, FIFO checks empty itself
    assign pop     = access && req.pwrite && (req.paddr == REG_POP);
    assign clr_ovf = pop && req.pwdata[0];

endmodule

`default_nettype wire

/* trace_fifo.sv */
/*
 * synchronous trace record FIFO
 * full, empty, occupancy count and sticky overflow
 */
`default_nettype none

module trace_fifo #(
    parameter int unsigned DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  pipe_trace_pkg::trace_rec_t push_rec,
    input  logic                       pop,
    input  logic                       clr_ovf,
    output pipe_trace_pkg::trace_rec_t head,
    output logic                       empty,
    output logic [$clog2(DEPTH):0]     count,
    output logic                       overflow
);
    import pipe_trace_pkg::*;

    localparam int unsigned AW = $clog2(DEPTH);

    // record storage
    trace_rec_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   cnt_q;
    logic          ovf_q;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full    = (cnt_q == (AW + 1)'(DEPTH));
    assign empty   = (cnt_q == '0);
    // drop when full, ignore pop when empty
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt_q  <= '0;
            ovf_q  <= 1'b0;
        end else begin
            // pointers wrap on power-of-two depth
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
            // a lost record wins over a clear
            if (push && full) begin
                ovf_q <= 1'b1;
            end else if (pop && clr_ovf) begin
                ovf_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    // head shown combinationally
    assign head     = mem[rd_ptr];
    assign count    = cnt_q;
    assign overflow = ovf_q;

endmodule

`default_nettype wire

/* trace_tracker.sv */
/*
 * five-stage pipeline shadow
 * stamps fetch, execute and write-back cycles, counts stalls, emits records
 */
`default_nettype none

module trace_tracker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fetch_valid,
    input  logic [31:0]                fetch_instr,
    input  logic                       stall,
    input  logic                       flush,
    output logic                       rec_valid,
    output pipe_trace_pkg::trace_rec_t rec
);
    import pipe_trace_pkg::*;

    // slot valid bits
    logic f_vld;
    logic d_vld;
    logic e_vld;
    logic m_vld;
    logic w_vld;

    // slot payloads
    trace_rec_t f_rec;
    trace_rec_t d_rec;
    trace_rec_t e_rec;
    trace_rec_t m_rec;
    trace_rec_t w_rec;

    // next payloads for F, E and W
    trace_rec_t fetch_rec;
    trace_rec_t e_in;
    trace_rec_t w_in;

    logic [7:0] seq_q;
    cycle_t     cycle_q;
    // F and D move on this edge
    logic       advance;

    // stall count tops out at 255
    function automatic logic [7:0] sat_inc(input logic [7:0] v);
        return (v == 8'hff) ? v : v + 8'd1;
    endfunction

    assign advance = !flush && !stall;

    ////////////////////
    // slot inputs
    ////////////////////

    always_comb begin
        // new record at fetch acceptance
        fetch_rec             = '0;
        fetch_rec.instr       = fetch_instr;
        fetch_rec.seq         = seq_q;
        fetch_rec.fetch_cycle = cycle_q;

        // stamp on entry to execute
        e_in            = d_rec;
        e_in.exec_cycle = cycle_q;

        // stamp on entry to write-back
        w_in          = m_rec;
        w_in.wb_cycle = cycle_q;
    end

    ////////////////////
    // control state
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            f_vld   <= 1'b0;
            d_vld   <= 1'b0;
            e_vld   <= 1'b0;
            m_vld   <= 1'b0;
            w_vld   <= 1'b0;
            seq_q   <= 8'd0;
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
            // M and W never hold
            m_vld   <= e_vld;
            w_vld   <= m_vld;
            if (flush) begin
                // F and D squashed, E gets a bubble
                f_vld <= 1'b0;
                d_vld <= 1'b0;
                e_vld <= 1'b0;
            end else if (stall) begin
                // F and D hold
                e_vld <= 1'b0;
            end else begin
                e_vld <= d_vld;
                d_vld <= f_vld;
                f_vld <= fetch_valid;
                // seq only consumed by an accepted fetch
                if (fetch_valid) begin
                    seq_q <= seq_q + 8'd1;
                end
            end
        end
    end

    ////////////////////
    // payloads
    ////////////////////

    always_ff @(posedge clk) begin
        w_rec <= w_in;
        m_rec <= e_rec;
        if (advance) begin
            e_rec <= e_in;
            d_rec <= f_rec;
            f_rec <= fetch_rec;
        end else if (!flush) begin
            // held slots count the stall
            if (f_vld) begin
                f_rec.stalls <= sat_inc(f_rec.stalls);
            end
            if (d_vld) begin
                d_rec.stalls <= sat_inc(d_rec.stalls);
            end
        end
    end

    // retiring instruction goes straight out
    assign rec_valid = w_vld;
    assign rec       = w_rec;

endmodule

`default_nettype wire

/* pipe_trace_pkg.sv */
/*
 * shared types for the pipeline trace unit
 * trace record, cycle stamp, APB request and response, register offsets
 */
`default_nettype none

package pipe_trace_pkg;

    ////////////////////
    // trace record
    ////////////////////

    // 16-bit free running cycle stamp
    typedef logic [15:0] cycle_t;

    // one retired instruction, 96 bits
    typedef struct packed {
        logic [31:0] instr;
        // fetch order, wraps
        logic [7:0]  seq;
        // cycles held in fetch or decode, saturating
        logic [7:0]  stalls;
        cycle_t      fetch_cycle;
        cycle_t      exec_cycle;
        cycle_t      wb_cycle;
    } trace_rec_t;

    ////////////////////
    // APB
    ////////////////////

    // master to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        // byte address
        logic [4:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // slave to master, zero-wait so no pready
    typedef struct packed {
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    // register map
    localparam logic [4:0] REG_STATUS = 5'h00;
    localparam logic [4:0] REG_INSTR  = 5'h04;
    localparam logic [4:0] REG_INFO   = 5'h08;
    localparam logic [4:0] REG_CYCLES = 5'h0C;
    localparam logic [4:0] REG_POP    = 5'h10;

endpackage

`default_nettype wire
